/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pitaya_top
FILELIST  ?= pitaya_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* pitaya_top.f */
verilog/pitaya_pkg.sv
verilog/analog_frontend.sv
verilog/sys_bus_decoder.sv
verilog/housekeeping_regs.sv
verilog/p_controller.sv
verilog/dac_mixer.sv
verilog/pitaya_top.sv
testbench/tb_clk_gen.sv
testbench/tb_pitaya_top.sv

/* testbench/tb_clk_gen.sv */
`timescale 1ns/100ps
// adc_clk source for the testbench, 10 ns period
// reset held low for 8 cycles, released on a falling edge
module tb_clk_gen (
  output logic adc_clk_o,
  output logic rst_n_o
);

  initial begin
    adc_clk_o = 1'b0;
    rst_n_o   = 1'b0;
    repeat (8) @(posedge adc_clk_o);
    @(negedge adc_clk_o);
    rst_n_o = 1'b1;  // away from the sampling edge
  end

  always #5 adc_clk_o = ~adc_clk_o;

endmodule

/* testbench/tb_pitaya_top.sv */
`timescale 1ns/100ps
// pitaya_top testbench with bus stimulus, analog stream and a reference model
// checking is done by concurrent assertions on bus responses and dac pins
module tb_pitaya_top
  import pitaya_pkg::*;
;
  logic adc_clk, rst_n;
  logic [adc_w-1:0] adc_dat_a, adc_dat_b, dac_dat_a, dac_dat_b;
  logic [bus_w-1:0] sys_addr, sys_wdata, sys_rdata;
  logic [sel_w-1:0] sys_sel;
  logic sys_wen, sys_ren, sys_ack, sys_err;
  logic [led_w-1:0] led;
  int seed = 32'ha799_d362;
  int val_err = 0;    // wrong values
  int proto_err = 0;  // missing or stray handshakes
  int cycles = 0;
  string test_name = "reset";
  // model state updated by the bus rules
  logic [led_w-1:0] m_led;
  logic [adc_w-1:0] m_sp_a, m_kp_a, m_sp_b, m_kp_b, m_dc_a, m_dc_b;
  logic [adc_w-1:0] hist_a [5], hist_b [5];  // adc words the dut sampled
  logic [3:0] settle;          // cycles since last write
  logic acc_pend, rd_pend;     // used-region access one cycle ago
  logic [bus_w-1:0] rd_exp;
  logic addr_used, dac_ok;
  logic [adc_w-1:0] exp_a, exp_b;

  tb_clk_gen i_clk (.adc_clk_o(adc_clk), .rst_n_o(rst_n));

  pitaya_top dut (
    .adc_clk(adc_clk), .rst_n_i(rst_n),
    .adc_dat_a_i(adc_dat_a), .adc_dat_b_i(adc_dat_b),
    .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata), .sys_sel_i(sys_sel),
    .sys_wen_i(sys_wen), .sys_ren_i(sys_ren),
    .dac_dat_a_o(dac_dat_a), .dac_dat_b_o(dac_dat_b), .led_o(led),
    .sys_rdata_o(sys_rdata), .sys_ack_o(sys_ack), .sys_err_o(sys_err)
  );

  // --------------------
  // reference model
  function automatic logic is_used(input logic [2:0] r);
    return (r == region_hk) || (r == region_mix) || (r == region_pid);
  endfunction

  function automatic int clip14(input int v);
    if (v > 8191) return 8191;   // 14 bit max
    if (v < -8192) return -8192;
    return v;
  endfunction

  // msb kept and low 13 bits flipped between converter code and two's complement
  function automatic logic [adc_w-1:0] dac_expect(input logic [adc_w-1:0] raw,
      input logic signed [adc_w-1:0] sp, input logic signed [adc_w-1:0] kp,
      input logic signed [adc_w-1:0] dc);
    logic signed [adc_w-1:0] s;
    logic [31:0] sum_w32;
    int e, p;
    s = {raw[13], ~raw[12:0]};
    e = int'(sp) - int'(s);
    p = clip14((e * int'(kp)) >>> kp_shift);
    sum_w32 = clip14(p + int'(dc));
    return {sum_w32[13], ~sum_w32[12:0]};
  endfunction

  function automatic logic [bus_w-1:0] read_expect(input logic [bus_w-1:0] a);
    logic [offset_w-1:0] o;
    o = a[offset_w-1:0];
    case (a[region_msb:region_lsb])
      region_hk: begin
        if (o == hk_id_ofs) return hk_id_val;
        if (o == hk_led_ofs) return {24'd0, m_led};
      end
      region_pid: begin
        if (o == pid_sp_a_ofs) return {{18{m_sp_a[13]}}, m_sp_a};
        if (o == pid_kp_a_ofs) return {{18{m_kp_a[13]}}, m_kp_a};
        if (o == pid_sp_b_ofs) return {{18{m_sp_b[13]}}, m_sp_b};
        if (o == pid_kp_b_ofs) return {{18{m_kp_b[13]}}, m_kp_b};
      end
      region_mix: begin
        if (o == mix_dc_a_ofs) return {{18{m_dc_a[13]}}, m_dc_a};
        if (o == mix_dc_b_ofs) return {{18{m_dc_b[13]}}, m_dc_b};
      end
      default: ;
    endcase
    return '0;  // unknown offset or unused region
  endfunction

  always @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      m_led    <= '0;
      m_sp_a   <= '0;
      m_kp_a   <= '0;
      m_sp_b   <= '0;
      m_kp_b   <= '0;
      m_dc_a   <= '0;
      m_dc_b   <= '0;
      settle   <= '0;
      acc_pend <= 1'b0;
      rd_pend  <= 1'b0;
      rd_exp   <= '0;
    end else begin
      acc_pend <= (sys_wen | sys_ren) & addr_used;
      rd_pend  <= sys_ren & addr_used;
      if (sys_ren) rd_exp <= read_expect(sys_addr);
      if (sys_wen) begin
        settle <= '0;  // pipeline holds old settings for a while
        case (sys_addr[region_msb:region_lsb])
          region_hk: if (sys_addr[19:0] == hk_led_ofs) m_led <= sys_wdata[7:0];
          region_pid: begin
            if (sys_addr[19:0] == pid_sp_a_ofs) m_sp_a <= sys_wdata[13:0];
            if (sys_addr[19:0] == pid_kp_a_ofs) m_kp_a <= sys_wdata[13:0];
            if (sys_addr[19:0] == pid_sp_b_ofs) m_sp_b <= sys_wdata[13:0];
            if (sys_addr[19:0] == pid_kp_b_ofs) m_kp_b <= sys_wdata[13:0];
          end
          region_mix: begin
            if (sys_addr[19:0] == mix_dc_a_ofs) m_dc_a <= sys_wdata[13:0];
            if (sys_addr[19:0] == mix_dc_b_ofs) m_dc_b <= sys_wdata[13:0];
          end
          default: ;
        endcase
      end else if (settle < 4'd15) begin
        settle <= settle + 4'd1;
      end
    end
  end

  always @(posedge adc_clk) begin
    hist_a[0] <= adc_dat_a;  // word sampled at this edge
    hist_b[0] <= adc_dat_b;
    for (int i = 4; i > 0; i--) begin
      hist_a[i] <= hist_a[i-1];
      hist_b[i] <= hist_b[i-1];
    end
  end

  assign addr_used = is_used(sys_addr[region_msb:region_lsb]);
  assign dac_ok    = (settle >= 4'd6);
  assign exp_a     = dac_expect(hist_a[4], m_sp_a, m_kp_a, m_dc_a);
  assign exp_b     = dac_expect(hist_b[4], m_sp_b, m_kp_b, m_dc_b);

  // --------------------
  // checks
  reset_state: assert property (@(posedge adc_clk) $rose(rst_n) |->
    (!sys_ack && led == '0 && dac_dat_a == 14'h1fff && dac_dat_b == 14'h1fff))
    else begin proto_err++; $display("state after reset is not the idle state"); end
  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n)
    acc_pend |-> sys_ack)
    else begin proto_err++; $display("%s: ack missing one cycle after strobe", test_name); end
  no_stray_ack: assert property (@(posedge adc_clk) disable iff (!rst_n)
    (!acc_pend && addr_used) |-> !sys_ack)
    else begin proto_err++; $display("%s: ack without an access", test_name); end
  read_data: assert property (@(posedge adc_clk) disable iff (!rst_n)
    rd_pend |-> (sys_rdata == rd_exp))
    else begin val_err++; $display("[ERROR] %s rdata expected %h actual %h",
      test_name, rd_exp, sys_rdata); end
  unused_resp: assert property (@(posedge adc_clk) disable iff (!rst_n)
    !addr_used |-> (sys_ack && sys_rdata == '0))
    else begin proto_err++; $display("%s: unused region did not ack with zero", test_name); end
  no_err: assert property (@(posedge adc_clk) disable iff (!rst_n) !sys_err)
    else begin proto_err++; $display("%s: bus error raised", test_name); end
  led_follow: assert property (@(posedge adc_clk) disable iff (!rst_n) led == m_led)
    else begin val_err++; $display("[ERROR] %s led expected %h actual %h",
      test_name, m_led, led); end
  dac_a_chk: assert property (@(posedge adc_clk) disable iff (!rst_n)
    dac_ok |-> dac_dat_a == exp_a)
    else begin val_err++; $display("[ERROR] %s dac a expected %h actual %h",
      test_name, exp_a, dac_dat_a); end
  dac_b_chk: assert property (@(posedge adc_clk) disable iff (!rst_n)
    dac_ok |-> dac_dat_b == exp_b)
    else begin val_err++; $display("[ERROR] %s dac b expected %h actual %h",
      test_name, exp_b, dac_dat_b); end

  // --------------------
  // stimulus
  function automatic logic [bus_w-1:0] reg_addr(input logic [2:0] r,
                                                input logic [19:0] o);
    return {9'd0, r, o};
  endfunction

  task automatic wait_ack();
    int n;
    n = 0;
    @(negedge adc_clk);
    while (!sys_ack && n < 8) begin
      @(negedge adc_clk);
      n++;
    end
    if (!sys_ack) begin
      proto_err++;
      $display("%s: no ack within 8 cycles at address %h", test_name, sys_addr);
    end
  endtask

  task automatic bus_write(input logic [bus_w-1:0] a, input logic [bus_w-1:0] d);
    @(posedge adc_clk);
    sys_addr  <= a;
    sys_wdata <= d;
    sys_wen   <= 1'b1;
    @(posedge adc_clk);
    sys_wen   <= 1'b0;  // one cycle strobe
    wait_ack();
  endtask

  task automatic bus_read(input logic [bus_w-1:0] a);
    @(posedge adc_clk);
    sys_addr <= a;
    sys_ren  <= 1'b1;
    @(posedge adc_clk);
    sys_ren  <= 1'b0;
    wait_ack();
  endtask

  task automatic stream_adc(input int n);
    int r;
    repeat (n) begin
      @(posedge adc_clk);
      r = $random(seed);
      adc_dat_a <= r[13:0];
      adc_dat_b <= r[29:16];
    end
  endtask

  task automatic set_channel(input logic [13:0] sp, input logic [13:0] kp,
                             input logic [13:0] dc, input logic ch_b);
    bus_write(reg_addr(region_pid, ch_b ? pid_sp_b_ofs : pid_sp_a_ofs), {18'd0, sp});
    bus_write(reg_addr(region_pid, ch_b ? pid_kp_b_ofs : pid_kp_a_ofs), {18'd0, kp});
    bus_write(reg_addr(region_mix, ch_b ? mix_dc_b_ofs : mix_dc_a_ofs), {18'd0, dc});
  endtask

  always @(posedge adc_clk) begin
    cycles <= cycles + 1;
    if (cycles >= 3000) begin
      $display("timeout: run did not finish within 3000 cycles");
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    int r;
    adc_dat_a = '0;
    adc_dat_b = '0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_sel   = '1;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    wait (rst_n);
    test_name = "register round trip";
    r = $random(seed);
    bus_write(reg_addr(region_hk, hk_led_ofs), r);
    bus_read(reg_addr(region_hk, hk_led_ofs));
    for (int i = 0; i < 4; i++) begin
      bus_write(reg_addr(region_pid, 20'(4 * i)), $random(seed));
      bus_read(reg_addr(region_pid, 20'(4 * i)));
    end
    for (int i = 0; i < 2; i++) begin
      bus_write(reg_addr(region_mix, 20'(4 * i)), $random(seed));
      bus_read(reg_addr(region_mix, 20'(4 * i)));
    end
    bus_write(reg_addr(region_pid, 20'h00010), $random(seed));  // no such register
    bus_read(reg_addr(region_pid, 20'h00010));
    test_name = "id and unused regions";
    bus_read(reg_addr(region_hk, hk_id_ofs));
    bus_write(reg_addr(region_hk, hk_id_ofs), $random(seed));
    bus_read(reg_addr(region_hk, hk_id_ofs));
    for (int rg = 1; rg < 8; rg++) begin
      if (rg != 2 && rg != 3) begin
        bus_write(reg_addr(3'(rg), 20'h00000), $random(seed));
        bus_read(reg_addr(3'(rg), 20'h00004));
      end
    end
    test_name = "format conversion";
    set_channel(14'd0, 14'd0, 14'd0, 1'b0);
    set_channel(14'd0, 14'd0, 14'd0, 1'b1);
    stream_adc(40);
    r = $random(seed);
    set_channel(14'd0, 14'd0, r[13:0], 1'b0);
    set_channel(14'd0, 14'd0, r[29:16], 1'b1);
    stream_adc(40);
    test_name = "proportional path";
    repeat (4) begin
      r = $random(seed);
      set_channel(r[13:0], {{5{r[15]}}, r[24:16]}, 14'(r[31:26]), 1'b0);
      r = $random(seed);
      set_channel(r[13:0], {{5{r[15]}}, r[24:16]}, 14'(r[31:26]), 1'b1);
      stream_adc(150);
    end
    test_name = "saturation";
    set_channel(14'h1fff, 14'h1fff, 14'd4000, 1'b0);   // large positive
    set_channel(14'h2000, 14'h1fff, -14'sd4000, 1'b1); // large negative
    stream_adc(60);
    set_channel(14'h2000, 14'h2001, -14'sd8000, 1'b0);
    set_channel(14'h1fff, 14'h2001, 14'd8000, 1'b1);
    stream_adc(60);
    repeat (8) @(posedge adc_clk);
    $display("errors: value %0d, protocol %0d", val_err, proto_err);
    if (val_err == 0 && proto_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog/analog_frontend.sv */
`timescale 1ns/100ps
// adc and dac sample format conversion
// neg-slope offset binary <-> two's complement, one register each way
module analog_frontend
  import pitaya_pkg::*;
(
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic [adc_w-1:0] adc_dat_a_i,  // raw adc ch a
  input  logic [adc_w-1:0] adc_dat_b_i,  // raw adc ch b
  input  logic [adc_w-1:0] dac_a_i,      // two's compl from mixer
  input  logic [adc_w-1:0] dac_b_i,
  output logic [adc_w-1:0] adc_a_o,      // two's compl to controller
  output logic [adc_w-1:0] adc_b_o,
  output logic [adc_w-1:0] dac_dat_a_o,  // converter format
  output logic [adc_w-1:0] dac_dat_b_o
);

  // msb kept, low bits flipped; the mapping is its own inverse
  function automatic logic [adc_w-1:0] flip_low(input logic [adc_w-1:0] w);
    flip_low = {w[adc_w-1], ~w[adc_w-2:0]};
  endfunction

  // --------------------
  // adc side
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= flip_low(adc_dat_a_i);  // to signed
      adc_b_o <= flip_low(adc_dat_b_i);
    end
  end

  // --------------------
  // dac side
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_dat_a_o <= flip_low({adc_w{1'b0}});  // code of zero
      dac_dat_b_o <= flip_low({adc_w{1'b0}});
    end else begin
      dac_dat_a_o <= flip_low(dac_a_i);
      dac_dat_b_o <= flip_low(dac_b_i);
    end
  end

  // whole mixer/controller chain must resolve to known codes out of reset
  dac_known_chk: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !$isunknown({dac_dat_a_o, dac_dat_b_o}))
    else $error("dac pins unknown after reset");

endmodule

/* verilog/dac_mixer.sv */
`timescale 1ns/100ps
// dac mixer slave on region 2
// controller output plus programmable dc level clamped to 14 bits
module dac_mixer
  import pitaya_pkg::*;
(
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic [adc_w-1:0] pid_a_i,  // controller out
  input  logic [adc_w-1:0] pid_b_i,
  input  logic [bus_w-1:0] addr_i,
  input  logic [bus_w-1:0] wdata_i,
  input  logic             wen_i,
  input  logic             ren_i,
  output logic [adc_w-1:0] dac_a_o,  // two's compl to frontend
  output logic [adc_w-1:0] dac_b_o,
  output logic [bus_w-1:0] rdata_o,
  output logic             ack_o,
  output logic             err_o
);

  logic [offset_w-1:0]     ofs;
  logic signed [adc_w-1:0] dc_a, dc_b;    // dc levels
  logic signed [sum_w-1:0] sum_a, sum_b;  // one bit of headroom

  assign ofs   = addr_i[offset_w-1:0];
  assign err_o = 1'b0;

  assign sum_a = dc_a + $signed(pid_a_i);
  assign sum_b = dc_b + $signed(pid_b_i);

  // out of range when the top two bits differ, then clamp by sign
  function automatic logic [adc_w-1:0] clamp(input logic [sum_w-1:0] s);
    if (^s[sum_w-1:sum_w-2])
      clamp = {s[sum_w-1], {(adc_w-1){~s[sum_w-1]}}};
    else
      clamp = s[adc_w-1:0];
  endfunction

  // --------------------
  // bus registers
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dc_a <= '0;
      dc_b <= '0;
    end else if (wen_i) begin
      case (ofs)
        mix_dc_a_ofs: dc_a <= wdata_i[adc_w-1:0];
        mix_dc_b_ofs: dc_b <= wdata_i[adc_w-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      ack_o <= wen_i | ren_i;
      if (ren_i) begin
        case (ofs)
          mix_dc_a_ofs: rdata_o <= sext_sample(dc_a);
          mix_dc_b_ofs: rdata_o <= sext_sample(dc_b);
          default:      rdata_o <= '0;
        endcase
      end
    end
  end

  // --------------------
  // sum and clamp in one cycle
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_a_o <= '0;
      dac_b_o <= '0;
    end else begin
      dac_a_o <= clamp(sum_a);
      dac_b_o <= clamp(sum_b);
    end
  end

  // output stays inside 14 bits without wrapping to the opposite sign of the sum
  sat_a_chk: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    dac_a_o[adc_w-1] == $past(sum_a[sum_w-1]))
    else $error("ch a output wrapped past the 14 bit range");

  sat_b_chk: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    dac_b_o[adc_w-1] == $past(sum_b[sum_w-1]))
    else $error("ch b output wrapped past the 14 bit range");

endmodule

/* verilog/housekeeping_regs.sv */
`timescale 1ns/100ps
// housekeeping slave on region 0
// read-only id word and the led register
module housekeeping_regs
  import pitaya_pkg::*;
(
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic [bus_w-1:0] addr_i,
  input  logic [bus_w-1:0] wdata_i,
  input  logic             wen_i,    // region gated
  input  logic             ren_i,
  output logic [bus_w-1:0] rdata_o,
  output logic             ack_o,
  output logic             err_o,
  output logic [led_w-1:0] led_o     // straight from register
);

  logic [offset_w-1:0] ofs;  // offset inside region

  assign ofs   = addr_i[offset_w-1:0];
  assign err_o = 1'b0;  // no error cases

  // --------------------
  // write side, id writes fall through
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      led_o <= '0;
    end else if (wen_i && (ofs == hk_led_ofs)) begin
      led_o <= wdata_i[led_w-1:0];
    end
  end

  // --------------------
  // read side and ack, one cycle after strobe
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      ack_o <= wen_i | ren_i;  // unknown offsets ack too
      if (ren_i) begin
        case (ofs)
          hk_id_ofs:  rdata_o <= hk_id_val;
          hk_led_ofs: rdata_o <= {{(bus_w-led_w){1'b0}}, led_o};
          default:    rdata_o <= '0;
        endcase
      end
    end
  end

endmodule

/* verilog/p_controller.sv */
`timescale 1ns/100ps
// two channel proportional controller, region 3
// out = sat14((setpoint - adc) * kp >>> kp_shift), two cycle latency
module p_controller
  import pitaya_pkg::*;
(
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic [adc_w-1:0] adc_a_i,  // two's compl samples
  input  logic [adc_w-1:0] adc_b_i,
  input  logic [bus_w-1:0] addr_i,
  input  logic [bus_w-1:0] wdata_i,
  input  logic             wen_i,
  input  logic             ren_i,
  output logic [adc_w-1:0] pid_a_o,  // to mixer
  output logic [adc_w-1:0] pid_b_o,
  output logic [bus_w-1:0] rdata_o,
  output logic             ack_o,
  output logic             err_o
);

  logic [offset_w-1:0]     ofs;
  logic signed [adc_w-1:0] sp_a, kp_a;  // setpoint, gain ch a
  logic signed [adc_w-1:0] sp_b, kp_b;  // ch b
  logic signed [sum_w-1:0] err_a, err_b;  // stage 1

  assign ofs   = addr_i[offset_w-1:0];
  assign err_o = 1'b0;

  // full product, shift, then clamp to 14 bits
  function automatic logic [adc_w-1:0] kp_scale(input logic signed [sum_w-1:0] err,
                                                input logic signed [adc_w-1:0] kp);
    logic signed [sum_w+adc_w-1:0] prod;
    logic [sum_w:0]                hi;  // bits above the kept range plus its sign
    prod = (err * kp) >>> kp_shift;
    hi   = prod[sum_w+adc_w-1:adc_w-1];
    if ((&hi) || !(|hi))
      kp_scale = prod[adc_w-1:0];
    else
      kp_scale = {prod[sum_w+adc_w-1], {(adc_w-1){~prod[sum_w+adc_w-1]}}};
  endfunction

  // --------------------
  // bus registers
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sp_a <= '0;
      kp_a <= '0;
      sp_b <= '0;
      kp_b <= '0;
    end else if (wen_i) begin
      case (ofs)
        pid_sp_a_ofs: sp_a <= wdata_i[adc_w-1:0];
        pid_kp_a_ofs: kp_a <= wdata_i[adc_w-1:0];
        pid_sp_b_ofs: sp_b <= wdata_i[adc_w-1:0];
        pid_kp_b_ofs: kp_b <= wdata_i[adc_w-1:0];
        default: ;  // ignored
      endcase
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      ack_o <= wen_i | ren_i;
      if (ren_i) begin
        case (ofs)
          pid_sp_a_ofs: rdata_o <= sext_sample(sp_a);
          pid_kp_a_ofs: rdata_o <= sext_sample(kp_a);
          pid_sp_b_ofs: rdata_o <= sext_sample(sp_b);
          pid_kp_b_ofs: rdata_o <= sext_sample(kp_b);
          default:      rdata_o <= '0;
        endcase
      end
    end
  end

  // --------------------
  // datapath, error then scaled output
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_a   <= '0;
      err_b   <= '0;
      pid_a_o <= '0;
      pid_b_o <= '0;
    end else begin
      err_a   <= sp_a - $signed(adc_a_i);  // 15 bit, cannot overflow
      err_b   <= sp_b - $signed(adc_b_i);
      pid_a_o <= kp_scale(err_a, kp_a);
      pid_b_o <= kp_scale(err_b, kp_b);
    end
  end

endmodule

/* verilog/pitaya_pkg.sv */
// widths, bus region map and register offsets
// shared by the analog path and its register slaves
package pitaya_pkg;

  // --------------------
  // data widths
  localparam int adc_w    = 14;  // one adc or dac sample
  localparam int sum_w    = 15;  // mixer sum before clamp
  localparam int bus_w    = 32;  // bus address and data
  localparam int sel_w    = 4;   // byte select
  localparam int led_w    = 8;   // board leds
  localparam int offset_w = 20;  // address bits inside one region

  // --------------------
  // region map, 1 MiB per region
  localparam int n_regions  = 8;
  localparam int region_lsb = 20;
  localparam int region_msb = 22;

  localparam logic [region_msb-region_lsb:0] region_hk  = 3'd0;  // housekeeping
  localparam logic [region_msb-region_lsb:0] region_mix = 3'd2;  // dc levels
  localparam logic [region_msb-region_lsb:0] region_pid = 3'd3;  // p controller

  // --------------------
  // housekeeping registers
  localparam logic [offset_w-1:0] hk_id_ofs  = 20'h00000;
  localparam logic [offset_w-1:0] hk_led_ofs = 20'h00030;
  localparam logic [bus_w-1:0]    hk_id_val  = 32'h5250_0114;  // board id, read only

  // controller registers, all 14 bit signed
  localparam logic [offset_w-1:0] pid_sp_a_ofs = 20'h00000;
  localparam logic [offset_w-1:0] pid_kp_a_ofs = 20'h00004;
  localparam logic [offset_w-1:0] pid_sp_b_ofs = 20'h00008;
  localparam logic [offset_w-1:0] pid_kp_b_ofs = 20'h0000C;
  localparam int                  kp_shift     = 8;  // gain fraction bits

  // mixer dc levels, 14 bit signed
  localparam logic [offset_w-1:0] mix_dc_a_ofs = 20'h00000;
  localparam logic [offset_w-1:0] mix_dc_b_ofs = 20'h00004;

  // sample to bus word, sign extended for readback
  function automatic logic [bus_w-1:0] sext_sample(input logic [adc_w-1:0] s);
    sext_sample = {{(bus_w-adc_w){s[adc_w-1]}}, s};
  endfunction

endpackage

/* verilog/pitaya_top.sv */
`timescale 1ns/100ps
// top level, analog path and register bus
// frontend -> p controller -> dac mixer -> frontend, five cycles pin to pin
module pitaya_top
  import pitaya_pkg::*;
(
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic [adc_w-1:0] adc_dat_a_i,  // raw adc words
  input  logic [adc_w-1:0] adc_dat_b_i,
  input  logic [bus_w-1:0] sys_addr_i,
  input  logic [bus_w-1:0] sys_wdata_i,
  input  logic [sel_w-1:0] sys_sel_i,    // all registers are full word, no lane use
  input  logic             sys_wen_i,
  input  logic             sys_ren_i,
  output logic [adc_w-1:0] dac_dat_a_o,  // separate per channel
  output logic [adc_w-1:0] dac_dat_b_o,
  output logic [led_w-1:0] led_o,
  output logic [bus_w-1:0] sys_rdata_o,
  output logic             sys_ack_o,
  output logic             sys_err_o
);

  logic [adc_w-1:0]     adc_a, adc_b;  // signed samples
  logic [adc_w-1:0]     pid_a, pid_b;
  logic [adc_w-1:0]     dac_a, dac_b;
  logic [n_regions-1:0] wen, ren;      // region strobes
  logic [bus_w-1:0]     hk_rdata, mix_rdata, pid_rdata;
  logic                 hk_ack, mix_ack, pid_ack;
  logic                 hk_err, mix_err, pid_err;

  // --------------------
  // analog path
  analog_frontend i_frontend (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_a_i     (dac_a),
    .dac_b_i     (dac_b),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  // --------------------
  // bus decoder
  sys_bus_decoder i_decoder (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .hk_err_i    (hk_err),
    .mix_rdata_i (mix_rdata),
    .mix_ack_i   (mix_ack),
    .mix_err_i   (mix_err),
    .pid_rdata_i (pid_rdata),
    .pid_ack_i   (pid_ack),
    .pid_err_i   (pid_err),
    .wen_o       (wen),
    .ren_o       (ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  // --------------------
  // slaves
  housekeeping_regs i_hk (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .addr_i  (sys_addr_i),
    .wdata_i (sys_wdata_i),
    .wen_i   (wen[region_hk]),
    .ren_i   (ren[region_hk]),
    .rdata_o (hk_rdata),
    .ack_o   (hk_ack),
    .err_o   (hk_err),
    .led_o   (led_o)
  );

  p_controller i_pid (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .adc_a_i (adc_a),
    .adc_b_i (adc_b),
    .addr_i  (sys_addr_i),
    .wdata_i (sys_wdata_i),
    .wen_i   (wen[region_pid]),
    .ren_i   (ren[region_pid]),
    .pid_a_o (pid_a),
    .pid_b_o (pid_b),
    .rdata_o (pid_rdata),
    .ack_o   (pid_ack),
    .err_o   (pid_err)
  );

  dac_mixer i_mixer (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .pid_a_i (pid_a),
    .pid_b_i (pid_b),
    .addr_i  (sys_addr_i),
    .wdata_i (sys_wdata_i),
    .wen_i   (wen[region_mix]),
    .ren_i   (ren[region_mix]),
    .dac_a_o (dac_a),
    .dac_b_o (dac_b),
    .rdata_o (mix_rdata),
    .ack_o   (mix_ack),
    .err_o   (mix_err)
  );

endmodule

/* verilog/sys_bus_decoder.sv */
`timescale 1ns/100ps
// system bus decoder, eight regions on address bits 22:20
// strobe gating plus read data / ack / err return mux
module sys_bus_decoder
  import pitaya_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  logic [bus_w-1:0]     sys_addr_i,
  input  logic                 sys_wen_i,    // one cycle write strobe
  input  logic                 sys_ren_i,    // one cycle read strobe
  input  logic [bus_w-1:0]     hk_rdata_i,   // region 0
  input  logic                 hk_ack_i,
  input  logic                 hk_err_i,
  input  logic [bus_w-1:0]     mix_rdata_i,  // region 2
  input  logic                 mix_ack_i,
  input  logic                 mix_err_i,
  input  logic [bus_w-1:0]     pid_rdata_i,  // region 3
  input  logic                 pid_ack_i,
  input  logic                 pid_err_i,
  output logic [n_regions-1:0] wen_o,        // per region strobes
  output logic [n_regions-1:0] ren_o,
  output logic [bus_w-1:0]     sys_rdata_o,
  output logic                 sys_ack_o,
  output logic                 sys_err_o
);

  logic [region_msb-region_lsb:0] region;      // addressed region number
  logic [n_regions-1:0]           region_sel;  // one-hot of it

  assign region     = sys_addr_i[region_msb:region_lsb];
  assign region_sel = {{(n_regions-1){1'b0}}, 1'b1} << region;

  assign wen_o = region_sel & {n_regions{sys_wen_i}};
  assign ren_o = region_sel & {n_regions{sys_ren_i}};

  // --------------------
  // response mux
  always_comb begin
    sys_rdata_o = '0;    // unused regions read zero
    sys_ack_o   = 1'b1;  // and ack at once
    sys_err_o   = 1'b0;
    case (region)
      region_hk: begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = hk_ack_i;
        sys_err_o   = hk_err_i;
      end
      region_mix: begin
        sys_rdata_o = mix_rdata_i;
        sys_ack_o   = mix_ack_i;
        sys_err_o   = mix_err_i;
      end
      region_pid: begin
        sys_rdata_o = pid_rdata_i;
        sys_ack_o   = pid_ack_i;
        sys_err_o   = pid_err_i;
      end
      default: ;  // regions 1, 4..7
    endcase
  end

  // master never raises both strobes, so one region at most sees one
  one_strobe_chk: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $onehot0({wen_o, ren_o}))
    else $error("more than one region strobe in a cycle");

endmodule
